//--- Makefile
SOURCES = hw/fetch_pkg.sv hw/rv_isa_pkg.sv hw/fetch_queue.sv hw/pc_unit.sv \
          hw/instr_predecoder.sv hw/fetch_stage.sv tests/tb_fetch_stage.sv

.PHONY: all run clean

all: run

obj_dir/Vtb_fetch_stage: $(SOURCES) files.f
	verilator --binary --timing --assert -f files.f --top-module tb_fetch_stage

run: obj_dir/Vtb_fetch_stage
	./obj_dir/Vtb_fetch_stage | tee sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- files.f
hw/fetch_pkg.sv
hw/rv_isa_pkg.sv
hw/fetch_queue.sv
hw/pc_unit.sv
hw/instr_predecoder.sv
hw/fetch_stage.sv
tests/tb_fetch_stage.sv

//--- hw/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    ////////////////////////////////////////////////////////////
    // Datapath widths
    ////////////////////////////////////////////////////////////

    // Address and instruction width
    localparam int XLEN = 32;

    // First fetch address after reset
    localparam logic [XLEN-1:0] RESET_VECTOR = 32'h8000_0000;

    ////////////////////////////////////////////////////////////
    // Hazard codes from the pipeline control
    ////////////////////////////////////////////////////////////

    // These two freeze the PC, every other code lets fetch run
    localparam logic [3:0] HZ_STALL_EARLY = 4'b0001;
    localparam logic [3:0] HZ_STALL_MMU   = 4'b0010;

    ////////////////////////////////////////////////////////////
    // Fetch queue sizing
    ////////////////////////////////////////////////////////////

    // Entries of PC and instruction pairs
    localparam int QUEUE_DEPTH = 4;

    // Pointer width, log2 of the depth
    localparam int QUEUE_PTR_W = 2;

endpackage

`default_nettype wire

//--- hw/fetch_queue.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_queue
    import fetch_pkg::*;
(
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic            push,
    input  wire logic [XLEN-1:0] push_pc,
    input  wire logic [XLEN-1:0] push_instr,
    input  wire logic            pop,
    input  wire logic            flush,
    output logic      [XLEN-1:0] head_pc,
    output logic      [XLEN-1:0] head_instr,
    output logic                 empty,
    output logic                 nearly_full
);

    logic [XLEN-1:0]        pc_mem    [QUEUE_DEPTH];
    logic [XLEN-1:0]        instr_mem [QUEUE_DEPTH];
    logic [QUEUE_PTR_W-1:0] wr_ptr;
    logic [QUEUE_PTR_W-1:0] rd_ptr;
    logic [QUEUE_PTR_W:0]   count;
    logic                   full;

    assign empty       = (count == '0);
    assign full        = (count == (QUEUE_PTR_W+1)'(QUEUE_DEPTH));
    // One slot or none left
    assign nearly_full = (count >= (QUEUE_PTR_W+1)'(QUEUE_DEPTH - 1));

    assign head_pc    = pc_mem[rd_ptr];
    assign head_instr = instr_mem[rd_ptr];

    ////////////////////////////////////////////////////////////
    // Pointers and occupancy
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + QUEUE_PTR_W'(1);
            end
            if (pop) begin
                rd_ptr <= rd_ptr + QUEUE_PTR_W'(1);
            end
            case ({push, pop})
                2'b10:   count <= count + (QUEUE_PTR_W+1)'(1);
                2'b01:   count <= count - (QUEUE_PTR_W+1)'(1);
                default: count <= count;
            endcase
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (push && !flush) begin
            pc_mem[wr_ptr]    <= push_pc;
            instr_mem[wr_ptr] <= push_instr;
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks on the neighbours' strobes
    ////////////////////////////////////////////////////////////

    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (rst) pop |-> !empty
    ) else $error("fetch_queue: pop while empty");

    a_no_push_full: assert property (
        @(posedge clk) disable iff (rst) push |-> !full
    ) else $error("fetch_queue: push while full");

endmodule

`default_nettype wire

//--- hw/fetch_stage.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_stage
    import fetch_pkg::*;
    import rv_isa_pkg::*;
(
    input  wire logic            clk,
    input  wire logic            rst,
    // Redirects from CSR and execute
    input  wire logic            trap_valid,
    input  wire logic [XLEN-1:0] trap_target,
    input  wire logic            branch_resolve,
    input  wire logic            mispredict,
    input  wire logic [XLEN-1:0] alu_target,
    input  wire logic [XLEN-1:0] saved_pc,
    // Pipeline control
    input  wire logic [3:0]      hazard,
    input  wire logic            fence,
    input  wire logic            decode_stall,
    // Instruction memory, one cycle read latency
    output logic      [XLEN-1:0] imem_addr,
    input  wire logic [XLEN-1:0] imem_rdata,
    // To decode
    output logic                 dec_valid,
    output logic      [XLEN-1:0] dec_pc,
    output logic      [XLEN-1:0] dec_instr,
    output instr_class_t         dec_class,
    output logic      [XLEN-1:0] dec_imm
);

    logic            push;
    logic [XLEN-1:0] push_pc;
    logic [XLEN-1:0] push_instr;
    logic            flush;
    logic            pop;
    logic [XLEN-1:0] head_pc;
    logic [XLEN-1:0] head_instr;
    logic            empty;
    logic            nearly_full;

    pc_unit u_pc_unit (
        .clk            (clk),
        .rst            (rst),
        .trap_valid     (trap_valid),
        .trap_target    (trap_target),
        .branch_resolve (branch_resolve),
        .mispredict     (mispredict),
        .alu_target     (alu_target),
        .saved_pc       (saved_pc),
        .hazard         (hazard),
        .fence          (fence),
        .nearly_full    (nearly_full),
        .imem_rdata     (imem_rdata),
        .imem_addr      (imem_addr),
        .push           (push),
        .push_pc        (push_pc),
        .push_instr     (push_instr),
        .flush          (flush)
    );

    fetch_queue u_fetch_queue (
        .clk         (clk),
        .rst         (rst),
        .push        (push),
        .push_pc     (push_pc),
        .push_instr  (push_instr),
        .pop         (pop),
        .flush       (flush),
        .head_pc     (head_pc),
        .head_instr  (head_instr),
        .empty       (empty),
        .nearly_full (nearly_full)
    );

    instr_predecoder u_instr_predecoder (
        .clk          (clk),
        .rst          (rst),
        .head_pc      (head_pc),
        .head_instr   (head_instr),
        .empty        (empty),
        .decode_stall (decode_stall),
        .flush        (flush),
        .pop          (pop),
        .dec_valid    (dec_valid),
        .dec_pc       (dec_pc),
        .dec_instr    (dec_instr),
        .dec_class    (dec_class),
        .dec_imm      (dec_imm)
    );

endmodule

`default_nettype wire

//--- hw/instr_predecoder.sv
`timescale 1ns/100ps
`default_nettype none

module instr_predecoder
    import fetch_pkg::*;
    import rv_isa_pkg::*;
(
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic [XLEN-1:0] head_pc,
    input  wire logic [XLEN-1:0] head_instr,
    input  wire logic            empty,
    input  wire logic            decode_stall,
    input  wire logic            flush,
    output logic                 pop,
    output logic                 dec_valid,
    output logic      [XLEN-1:0] dec_pc,
    output logic      [XLEN-1:0] dec_instr,
    output instr_class_t         dec_class,
    output logic      [XLEN-1:0] dec_imm
);

    instr_class_t    cls;
    imm_fmt_t        fmt;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] ins;

    assign ins = head_instr;
    assign pop = !empty && !decode_stall;

    // Opcode to class and immediate layout
    always_comb begin
        case (ins[6:0])
            OP_IMM:    begin cls = CL_ALU;     fmt = IMM_I;    end
            OP_REG:    begin cls = CL_ALU;     fmt = IMM_NONE; end
            OP_LUI:    begin cls = CL_UPPER;   fmt = IMM_U;    end
            OP_AUIPC:  begin cls = CL_UPPER;   fmt = IMM_U;    end
            OP_JAL:    begin cls = CL_JAL;     fmt = IMM_J;    end
            OP_JALR:   begin cls = CL_JALR;    fmt = IMM_I;    end
            OP_BRANCH: begin cls = CL_BRANCH;  fmt = IMM_B;    end
            OP_LOAD:   begin cls = CL_LOAD;    fmt = IMM_I;    end
            OP_STORE:  begin cls = CL_STORE;   fmt = IMM_S;    end
            OP_FENCE:  begin cls = CL_FENCE;   fmt = IMM_NONE; end
            OP_SYSTEM: begin cls = CL_SYSTEM;  fmt = IMM_I;    end
            default:   begin cls = CL_ILLEGAL; fmt = IMM_NONE; end
        endcase
    end

    // Sign extension always from bit 31
    always_comb begin
        case (fmt)
            IMM_I:   imm = {{20{ins[31]}}, ins[31:20]};
            IMM_S:   imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            IMM_B:   imm = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            IMM_U:   imm = {ins[31:12], 12'b0};
            IMM_J:   imm = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Output register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            dec_valid <= 1'b0;
        end else if (!decode_stall) begin
            dec_valid <= pop;
        end
    end

    // Payload holds while decode is stalled
    always_ff @(posedge clk) begin
        if (pop && !flush) begin
            dec_pc    <= head_pc;
            dec_instr <= head_instr;
            dec_class <= cls;
            dec_imm   <= imm;
        end
    end

    a_valid_known: assert property (
        @(posedge clk) disable iff (rst) !$isunknown(dec_valid)
    ) else $error("instr_predecoder: dec_valid unknown");

endmodule

`default_nettype wire

//--- hw/pc_unit.sv
`timescale 1ns/100ps
`default_nettype none

module pc_unit
    import fetch_pkg::*;
    import rv_isa_pkg::*;
(
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic            trap_valid,
    input  wire logic [XLEN-1:0] trap_target,
    input  wire logic            branch_resolve,
    input  wire logic            mispredict,
    input  wire logic [XLEN-1:0] alu_target,
    input  wire logic [XLEN-1:0] saved_pc,
    input  wire logic [3:0]      hazard,
    input  wire logic            fence,
    input  wire logic            nearly_full,
    input  wire logic [XLEN-1:0] imem_rdata,
    output logic      [XLEN-1:0] imem_addr,
    output logic                 push,
    output logic      [XLEN-1:0] push_pc,
    output logic      [XLEN-1:0] push_instr,
    output logic                 flush
);

    logic [XLEN-1:0] pc;
    logic            pend_valid;
    logic [XLEN-1:0] pend_pc;
    logic            jump_pend;
    logic [XLEN-1:0] jump_saved;
    logic            hold;
    logic            jal_seen;
    logic            take_jump;
    logic [XLEN-1:0] j_imm;
    logic [XLEN-1:0] jal_target;
    logic [XLEN-1:0] jump_target;

    ////////////////////////////////////////////////////////////
    // Control decisions
    ////////////////////////////////////////////////////////////

    // Queue room is checked with one read still in flight
    assign hold = (hazard == HZ_STALL_EARLY) || (hazard == HZ_STALL_MMU)
                  || fence || nearly_full;

    assign flush = trap_valid || branch_resolve;

    // Early jump detection on the returning word
    assign jal_seen = pend_valid && (imem_rdata[6:0] == OP_JAL);
    assign j_imm    = {{12{imem_rdata[31]}}, imem_rdata[19:12], imem_rdata[20],
                       imem_rdata[30:21], 1'b0};

    // PC already sits one word past the JAL here
    assign jal_target = pc + j_imm - 32'd4;

    // A jump seen under hold is parked until the hold lifts
    assign take_jump   = !hold && (jal_seen || jump_pend);
    assign jump_target = jump_pend ? jump_saved : jal_target;

    assign imem_addr  = pc;
    assign push       = pend_valid && !flush;
    assign push_pc    = pend_pc;
    assign push_instr = imem_rdata;

    ////////////////////////////////////////////////////////////
    // PC register and in-flight tracking
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            pc         <= RESET_VECTOR;
            pend_valid <= 1'b0;
            jump_pend  <= 1'b0;
        end else begin
            // Redirects and early jumps drop the read issued this cycle
            pend_valid <= !hold && !flush && !take_jump;

            if (trap_valid) begin
                pc <= trap_target;
            end else if (branch_resolve) begin
                pc <= mispredict ? saved_pc + 32'd4 : alu_target;
            end else if (hold) begin
                pc <= pc;
            end else if (take_jump) begin
                pc <= jump_target;
            end else begin
                pc <= pc + 32'd4;
            end

            if (flush) begin
                jump_pend <= 1'b0;
            end else if (hold && jal_seen) begin
                jump_pend <= 1'b1;
            end else if (take_jump) begin
                jump_pend <= 1'b0;
            end
        end
    end

    // Address of the read now in flight, and a parked jump target
    always_ff @(posedge clk) begin
        pend_pc <= pc;
        if (hold && jal_seen) begin
            jump_saved <= jal_target;
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    a_pc_aligned: assert property (
        @(posedge clk) disable iff (rst) pc[1:0] == 2'b00
    ) else $error("pc_unit: PC not word aligned");

    // Flush kills both the current response and the one behind it
    a_flush_no_push: assert property (
        @(posedge clk) disable iff (rst) flush |-> !push ##1 !push
    ) else $error("pc_unit: push around a flush");

endmodule

`default_nettype wire

//--- hw/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    ////////////////////////////////////////////////////////////
    // RV32I major opcodes, bits [6:0]
    ////////////////////////////////////////////////////////////

    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_FENCE  = 7'b0001111;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    // Coarse class handed to decode
    typedef enum logic [3:0] {
        CL_ALU,
        CL_LOAD,
        CL_STORE,
        CL_BRANCH,
        CL_JAL,
        CL_JALR,
        CL_UPPER,
        CL_FENCE,
        CL_SYSTEM,
        CL_ILLEGAL
    } instr_class_t;

    // Immediate layouts of the base ISA
    typedef enum logic [2:0] {
        IMM_NONE,
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } imm_fmt_t;

endpackage

`default_nettype wire

//--- tests/tb_fetch_stage.sv
`timescale 1ns/100ps
`default_nettype none

module tb_fetch_stage
    import fetch_pkg::*;
    import rv_isa_pkg::*;
();

    logic            clk = 1'b0;
    logic            rst;
    logic            trap_valid;
    logic [XLEN-1:0] trap_target;
    logic            branch_resolve;
    logic            mispredict;
    logic [XLEN-1:0] alu_target;
    logic [XLEN-1:0] saved_pc;
    logic [3:0]      hazard;
    logic            fence;
    logic            decode_stall;
    logic [XLEN-1:0] imem_addr;
    logic [XLEN-1:0] imem_rdata = '0;
    logic            dec_valid;
    logic [XLEN-1:0] dec_pc;
    logic [XLEN-1:0] dec_instr;
    instr_class_t    dec_class;
    logic [XLEN-1:0] dec_imm;

    // Reference model state
    logic [31:0]     rng;
    logic [31:0]     exp_pc;
    logic            skip_next;
    logic            prev_hold;
    logic [31:0]     prev_pc;
    logic [31:0]     prev_instr;
    logic [31:0]     prev_imm;
    instr_class_t    prev_class;

    // Stimulus modes and counters
    logic            en_redirect;
    logic            en_stall;
    logic            en_dstall;
    logic            first_seen;
    logic            aborted;
    int              stall_left;
    int              cyc;
    int              results;
    int              jal_count;
    int              checks;
    int              errors;
    int              tests;

    fetch_stage uut (
        .clk            (clk),
        .rst            (rst),
        .trap_valid     (trap_valid),
        .trap_target    (trap_target),
        .branch_resolve (branch_resolve),
        .mispredict     (mispredict),
        .alu_target     (alu_target),
        .saved_pc       (saved_pc),
        .hazard         (hazard),
        .fence          (fence),
        .decode_stall   (decode_stall),
        .imem_addr      (imem_addr),
        .imem_rdata     (imem_rdata),
        .dec_valid      (dec_valid),
        .dec_pc         (dec_pc),
        .dec_instr      (dec_instr),
        .dec_class      (dec_class),
        .dec_imm        (dec_imm)
    );

    always #4 clk = ~clk;

    // Instruction memory with one cycle of read latency
    always @(posedge clk) begin
        imem_rdata <= mem_word(imem_addr);
    end

    ////////////////////////////////////////////////////////////
    // Random numbers and memory contents
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rand_next();
        rng = xorshift(rng);
        return rng;
    endfunction

    // Each word is a hash of the full address
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [31:0] h;
        logic [31:0] body;
        logic [20:0] off;
        logic [6:0]  op;
        h    = xorshift(xorshift(addr ^ 32'h5bd1_e995));
        body = xorshift(h ^ 32'h2545_f491);
        // Odd word count keeps the jump offset nonzero
        off  = 21'($signed({h[9:4], 1'b1, 2'b00}));
        if (h[2:0] == 3'd0) begin
            return {off[20], off[10:1], off[11], off[19:12], body[11:7], OP_JAL};
        end
        case (h[6:3])
            4'd0, 4'd1: op = OP_IMM;
            4'd2:       op = OP_REG;
            4'd3:       op = OP_LUI;
            4'd4:       op = OP_AUIPC;
            4'd5, 4'd6: op = OP_LOAD;
            4'd7:       op = OP_STORE;
            4'd8, 4'd9: op = OP_BRANCH;
            4'd10:      op = OP_FENCE;
            4'd11:      op = OP_JALR;
            4'd12:      op = OP_SYSTEM;
            default:    op = 7'b0001011;
        endcase
        return {body[31:7], op};
    endfunction

    function automatic logic [31:0] pick_target();
        logic [31:0] r;
        r = rand_next();
        return RESET_VECTOR + {20'h0, r[11:2], 2'b00};
    endfunction

    ////////////////////////////////////////////////////////////
    // Predecode model
    ////////////////////////////////////////////////////////////

    function automatic instr_class_t exp_class(input logic [31:0] ins);
        case (ins[6:0])
            OP_IMM, OP_REG:   return CL_ALU;
            OP_LUI, OP_AUIPC: return CL_UPPER;
            OP_LOAD:          return CL_LOAD;
            OP_STORE:         return CL_STORE;
            OP_BRANCH:        return CL_BRANCH;
            OP_JAL:           return CL_JAL;
            OP_JALR:          return CL_JALR;
            OP_FENCE:         return CL_FENCE;
            OP_SYSTEM:        return CL_SYSTEM;
            default:          return CL_ILLEGAL;
        endcase
    endfunction

    function automatic logic [31:0] exp_imm(input logic [31:0] ins);
        logic [31:0] i_imm;
        logic [20:0] j_imm;
        i_imm = $unsigned($signed(ins) >>> 20);
        // J offset is 21 bits with bit 20 as its sign
        j_imm = {ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        case (ins[6:0])
            OP_IMM, OP_JALR, OP_LOAD, OP_SYSTEM: return i_imm;
            OP_STORE:         return {i_imm[31:5], ins[11:7]};
            OP_BRANCH:        return {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            OP_LUI, OP_AUIPC: return {ins[31:12], 12'h000};
            OP_JAL:           return 32'($signed(j_imm));
            default:          return 32'h0;
        endcase
    endfunction

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("FAIL %0t: %s expected %h got %h", $time, what, expected, actual);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Each step checks the cycle just ended and drives the next
    ////////////////////////////////////////////////////////////

    task automatic step();
        logic        consumed;
        logic [31:0] w;
        logic [31:0] r;
        @(posedge clk);
        consumed = dec_valid && !decode_stall && !skip_next;
        if (cyc == 0) begin
            check("imem_addr is the reset vector", RESET_VECTOR, imem_addr);
        end
        if (skip_next) begin
            // PC takes the redirect target one edge after the request
            check("imem_addr after a redirect", exp_pc, imem_addr);
        end
        if (prev_hold) begin
            check("dec_valid held under decode_stall", 32'd1, 32'(dec_valid));
            check("dec_pc held", prev_pc, dec_pc);
            check("dec_instr held", prev_instr, dec_instr);
            check("dec_class held", 32'(prev_class), 32'(dec_class));
            check("dec_imm held", prev_imm, dec_imm);
        end
        if (consumed) begin
            if (!first_seen) begin
                check("first dec_pc is the reset vector", RESET_VECTOR, dec_pc);
                check("first result at least 3 cycles after reset", 32'd1, 32'(cyc >= 3));
                first_seen = 1'b1;
            end
            w = mem_word(exp_pc);
            check("dec_pc on the expected path", exp_pc, dec_pc);
            check("dec_instr", w, dec_instr);
            check("dec_class", 32'(exp_class(w)), 32'(dec_class));
            check("dec_imm", exp_imm(w), dec_imm);
            if (w[6:0] == OP_JAL) begin
                exp_pc = exp_pc + exp_imm(w);
                jal_count++;
            end else begin
                exp_pc = exp_pc + 32'd4;
            end
            results++;
        end
        skip_next  = 1'b0;
        prev_hold  = dec_valid && decode_stall && !(trap_valid || branch_resolve);
        prev_pc    = dec_pc;
        prev_instr = dec_instr;
        prev_class = dec_class;
        prev_imm   = dec_imm;
        // Trap wins over a branch in the same cycle
        if (trap_valid) begin
            exp_pc    = trap_target;
            skip_next = 1'b1;
        end else if (branch_resolve) begin
            exp_pc    = mispredict ? saved_pc + 32'd4 : alu_target;
            skip_next = 1'b1;
        end
        cyc++;

        r = rand_next();
        trap_target <= pick_target();
        alu_target  <= pick_target();
        saved_pc    <= pick_target();
        if (en_redirect && r[3:0] == 4'd0) begin
            // Kind 3 raises trap and branch together
            trap_valid     <= (r[5:4] == 2'd0) || (r[5:4] == 2'd3);
            branch_resolve <= (r[5:4] != 2'd0);
            mispredict     <= (r[5:4] == 2'd1) || (r[5:4] == 2'd3 && r[6]);
        end else begin
            trap_valid     <= 1'b0;
            branch_resolve <= 1'b0;
            mispredict     <= 1'b0;
        end
        if (en_stall) begin
            case (r[9:7])
                3'd0:    hazard <= HZ_STALL_EARLY;
                3'd1:    hazard <= HZ_STALL_MMU;
                3'd2:    hazard <= r[13:10] | 4'b0100;
                default: hazard <= 4'h0;
            endcase
            fence <= (r[17:14] == 4'd0);
        end else begin
            hazard <= 4'h0;
            fence  <= 1'b0;
        end
        if (!en_dstall) begin
            stall_left = 0;
            decode_stall <= 1'b0;
        end else if (stall_left > 0) begin
            stall_left = stall_left - 1;
            decode_stall <= 1'b1;
        end else if (r[20:18] == 3'd0) begin
            // Runs of up to 16 cycles fill the queue
            stall_left = int'(r[24:21]);
            decode_stall <= 1'b1;
        end else begin
            decode_stall <= 1'b0;
        end
    endtask

    task automatic run_test(input string name, input int want, input int want_jal,
                            input int limit);
        int start_res;
        int start_jal;
        int start_err;
        int n;
        if (!aborted) begin
            start_res = results;
            start_jal = jal_count;
            start_err = errors;
            n = 0;
            while (((results - start_res) < want || (jal_count - start_jal) < want_jal)
                   && n < limit) begin
                step();
                n++;
            end
            if ((results - start_res) < want || (jal_count - start_jal) < want_jal) begin
                $display("ERROR: test %s timed out after %0d cycles waiting for results",
                         name, limit);
                errors++;
                aborted = 1'b1;
            end else begin
                tests++;
                $display("test %s: %0d results, %0d jumps, %0d errors", name,
                         results - start_res, jal_count - start_jal, errors - start_err);
            end
        end
    endtask

    initial begin
        rst            <= 1'b1;
        trap_valid     <= 1'b0;
        trap_target    <= '0;
        branch_resolve <= 1'b0;
        mispredict     <= 1'b0;
        alu_target     <= '0;
        saved_pc       <= '0;
        hazard         <= 4'h0;
        fence          <= 1'b0;
        decode_stall   <= 1'b0;
        rng            = 32'd82;
        exp_pc         = RESET_VECTOR;
        skip_next      = 1'b0;
        prev_hold      = 1'b0;
        en_redirect    = 1'b0;
        en_stall       = 1'b0;
        en_dstall      = 1'b0;
        first_seen     = 1'b0;
        aborted        = 1'b0;
        stall_left     = 0;
        cyc            = 0;
        results        = 0;
        jal_count      = 0;
        checks         = 0;
        errors         = 0;
        tests          = 0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        run_test("sequential fetch", 40, 0, 400);
        run_test("early jal", 20, 12, 2000);
        en_redirect = 1'b1;
        run_test("redirects", 80, 0, 3000);
        en_redirect = 1'b0;
        en_stall    = 1'b1;
        en_dstall   = 1'b1;
        run_test("stalls and back-pressure", 100, 0, 5000);
        en_redirect = 1'b1;
        run_test("mixed with predecode", 150, 0, 8000);

        $display("tests %0d, results %0d, checks %0d, errors %0d",
                 tests, results, checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
